//--- correlator_pkg.sv
/*
 * Pulse correlator shared definitions.
 * Sizes, command opcodes, vector types, control states and the counter step.
 */

package correlator_pkg;

	localparam int NUM_INPUTS    = 3;  // Pulse lines.
	localparam int LAG_AUTO      = 4;  // Auto lags 0 to 3.
	localparam int LAG_CROSS     = 3;  // Cross lags -1, 0, +1.
	localparam int NUM_BASELINES = 3;  // Input pairs.
	localparam int DELAY_DEPTH   = 4;
	localparam int RESOLUTION    = 8;  // Counter width.
	localparam int NUM_COUNTS    = 21;
	localparam int FRAME_BYTES   = 23; // Two header bytes, then counts.
	localparam int MIN_EXPONENT  = 5;
	localparam int MAX_EXPONENT  = 12;

	localparam logic [3:0] FRAME_MARK = 4'hA;

	// Opcodes sit in the upper nibble of a command byte.
	localparam logic [3:0] CMD_SET_WINDOW = 4'h1;
	localparam logic [3:0] CMD_START      = 4'h2;
	localparam logic [3:0] CMD_STOP       = 4'h3;

	typedef logic [NUM_INPUTS-1:0]          pulse_vec_t;
	typedef logic [RESOLUTION-1:0]          count_t;
	typedef logic [3:0]                     exponent_t;
	typedef logic [7:0]                     frame_index_t;
	typedef logic [7:0]                     byte_t;
	typedef logic [MAX_EXPONENT-1:0]        window_count_t;
	typedef logic [$clog2(FRAME_BYTES)-1:0] byte_index_t;

	typedef enum logic {
		ST_IDLE,
		ST_INTEGRATE
	} ctrl_state_t;

	// Next value of one saturating coincidence counter.
	// A capture restarts the counter with the coincidence of the same cycle.
	function automatic count_t count_step(count_t current, logic hit, logic accumulate,
			logic capture);
		count_t next;
		if (capture)
			next = count_t'(hit);
		else if (accumulate && hit && current != '1)
			next = current + count_t'(1);
		else
			next = current; // Hold, or stuck at full scale.
		return next;
	endfunction

endpackage

//--- integration_ctrl_if.sv
/*
 * Integration window control.
 * Carries accumulate and capture strobes plus the frame header fields.
 */

`timescale 1ns/1ps

interface integration_ctrl_if import correlator_pkg::*; ();

	logic         accumulate;      // Counting enabled this cycle.
	logic         capture;         // Last cycle of a window.
	exponent_t    window_exponent; // Exponent of the running window.
	frame_index_t frame_index;

	modport control (
		output accumulate,
		output capture,
		output window_exponent,
		output frame_index
	);

	modport bank (
		input accumulate,
		input capture
	);

	modport serializer (
		input capture,
		input window_exponent,
		input frame_index
	);

endinterface

//--- pulse_delay_line.sv
/*
 * Pulse delay line.
 * Registers the sampled lines and shifts them through a chain of lag taps.
 */

`timescale 1ns/1ps

module pulse_delay_line import correlator_pkg::*; (
	input  logic       integration_clk,
	input  logic       reset,
	input  pulse_vec_t line_in,
	output pulse_vec_t taps [DELAY_DEPTH]
);

	// Tap 0 is the newest sample; tap n is n cycles older.
	// All correlator lags are read from this one chain, so every bank
	// sees the same view of history in a given cycle.
	always_ff @(posedge integration_clk) begin
		if (reset) begin
			for (int n = 0; n < DELAY_DEPTH; n++)
				taps[n] <= '0;
		end else begin
			taps[0] <= line_in; // Sample point for all lines.
			for (int n = 1; n < DELAY_DEPTH; n++)
				taps[n] <= taps[n-1];
		end
	end

endmodule

//--- auto_correlator.sv
/*
 * Auto-correlation bank.
 * Counts coincidences of each line with its own delayed copies, lags 0 to 3.
 */

`timescale 1ns/1ps

module auto_correlator import correlator_pkg::*; (
	input  logic       integration_clk,
	input  logic       reset,
	input  pulse_vec_t taps [DELAY_DEPTH],
	integration_ctrl_if.bank ctrl,
	output count_t     auto_counts [NUM_INPUTS*LAG_AUTO]
);

	logic [NUM_INPUTS*LAG_AUTO-1:0] hits;

	// Counter index is input-major, lag ascending.
	// Lag 0 pairs tap 0 with itself, so it counts pulses.
	always_comb begin
		for (int a = 0; a < NUM_INPUTS; a++) begin
			for (int y = 0; y < LAG_AUTO; y++)
				hits[a*LAG_AUTO+y] = taps[0][a] & taps[y][a];
		end
	end

	always_ff @(posedge integration_clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_INPUTS*LAG_AUTO; i++)
				auto_counts[i] <= '0;
		end else begin
			for (int i = 0; i < NUM_INPUTS*LAG_AUTO; i++) begin
				auto_counts[i] <= count_step(auto_counts[i], hits[i], ctrl.accumulate,
					ctrl.capture);
			end
		end
	end

endmodule

//--- cross_correlator.sv
/*
 * Cross-correlation bank.
 * Counts coincidences for every line pair at lags -1, 0 and +1.
 */

`timescale 1ns/1ps

module cross_correlator import correlator_pkg::*; (
	input  logic       integration_clk,
	input  logic       reset,
	input  pulse_vec_t taps [DELAY_DEPTH],
	integration_ctrl_if.bank ctrl,
	output count_t     cross_counts [NUM_BASELINES*LAG_CROSS]
);

	logic [NUM_BASELINES*LAG_CROSS-1:0] hits;

	// Pairs run (0,1), (0,2), (1,2); lags run -1 to +1 within a pair.
	// A negative lag delays line a, a positive lag delays line b.
	for (genvar a = 0; a < NUM_INPUTS; a++) begin : g_line_a
		for (genvar b = a + 1; b < NUM_INPUTS; b++) begin : g_line_b
			localparam int PAIR = a * (2 * NUM_INPUTS - a - 1) / 2 + (b - a - 1);
			for (genvar l = 0; l < LAG_CROSS; l++) begin : g_lag
				localparam int OFFSET = l - (LAG_CROSS - 1) / 2;
				localparam int TAP_A  = (OFFSET < 0) ? -OFFSET : 0;
				localparam int TAP_B  = (OFFSET > 0) ? OFFSET : 0;
				assign hits[PAIR*LAG_CROSS+l] = taps[TAP_A][a] & taps[TAP_B][b];
			end
		end
	end

	always_ff @(posedge integration_clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_BASELINES*LAG_CROSS; i++)
				cross_counts[i] <= '0;
		end else begin
			for (int i = 0; i < NUM_BASELINES*LAG_CROSS; i++) begin
				cross_counts[i] <= count_step(cross_counts[i], hits[i], ctrl.accumulate,
					ctrl.capture);
			end
		end
	end

endmodule

//--- integration_control.sv
/*
 * Integration controller.
 * Decodes command bytes and runs the window FSM that drives accumulate and
 * capture. Windows follow each other back to back until a stop.
 */

`timescale 1ns/1ps

module integration_control import correlator_pkg::*; (
	input  logic  integration_clk,
	input  logic  reset,
	input  logic  cmd_valid,
	input  byte_t cmd_data,
	output logic  integrating,
	integration_ctrl_if.control ctrl
);

	ctrl_state_t   state;
	exponent_t     pending_exp; // Applied at the next window start.
	exponent_t     active_exp;
	window_count_t win_count;
	window_count_t win_last;
	frame_index_t  frame_idx;
	logic          stop_pending;
	logic [3:0]    opcode;
	exponent_t     arg;
	exponent_t     clamped_exp;
	logic          cmd_start;
	logic          cmd_stop;
	logic          cmd_window;
	logic          window_end;

	assign opcode     = cmd_data[7:4];
	assign arg        = cmd_data[3:0];
	assign cmd_start  = cmd_valid && (opcode == CMD_START);
	assign cmd_stop   = cmd_valid && (opcode == CMD_STOP);
	assign cmd_window = cmd_valid && (opcode == CMD_SET_WINDOW);

	always_comb begin
		if (arg < exponent_t'(MIN_EXPONENT))
			clamped_exp = exponent_t'(MIN_EXPONENT);
		else if (arg > exponent_t'(MAX_EXPONENT))
			clamped_exp = exponent_t'(MAX_EXPONENT);
		else
			clamped_exp = arg;
	end

	assign win_last   = window_count_t'((32'd1 << active_exp) - 32'd1);
	assign window_end = (state == ST_INTEGRATE) && (win_count == win_last);

	always_ff @(posedge integration_clk) begin
		if (reset) begin
			state        <= ST_IDLE;
			pending_exp  <= exponent_t'(MIN_EXPONENT);
			active_exp   <= exponent_t'(MIN_EXPONENT);
			win_count    <= '0;
			frame_idx    <= '0;
			stop_pending <= 1'b0;
		end else begin
			if (cmd_window)
				pending_exp <= clamped_exp;
			case (state)
				ST_IDLE: begin
					if (cmd_start) begin // Stop while idle falls through.
						state        <= ST_INTEGRATE;
						active_exp   <= pending_exp;
						win_count    <= '0;
						stop_pending <= 1'b0;
					end
				end
				ST_INTEGRATE: begin
					if (window_end) begin
						win_count  <= '0;
						frame_idx  <= frame_idx + frame_index_t'(1); // Wraps at 255.
						active_exp <= cmd_window ? clamped_exp : pending_exp;
						if (stop_pending || cmd_stop) begin
							state        <= ST_IDLE;
							stop_pending <= 1'b0;
						end
					end else begin
						win_count <= win_count + window_count_t'(1);
						if (cmd_stop)
							stop_pending <= 1'b1;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	assign integrating          = (state == ST_INTEGRATE);
	assign ctrl.accumulate      = (state == ST_INTEGRATE);
	assign ctrl.capture         = window_end;
	assign ctrl.window_exponent = active_exp;
	assign ctrl.frame_index     = frame_idx;

endmodule

//--- frame_serializer.sv
/*
 * Frame serializer.
 * Snapshots header and counts on capture, then sends one byte per clock.
 */

`timescale 1ns/1ps

module frame_serializer import correlator_pkg::*; (
	input  logic   integration_clk,
	input  logic   reset,
	input  count_t auto_counts [NUM_INPUTS*LAG_AUTO],
	input  count_t cross_counts [NUM_BASELINES*LAG_CROSS],
	integration_ctrl_if.serializer ctrl,
	output byte_t  frame_byte,
	output logic   byte_valid,
	output logic   frame_start
);

	count_t       shadow [NUM_COUNTS];
	exponent_t    hdr_exp;
	frame_index_t hdr_idx;
	byte_index_t  byte_idx;
	byte_index_t  count_sel;
	logic         sending;

	// Auto counts first, cross counts after them.
	always_ff @(posedge integration_clk) begin
		if (ctrl.capture) begin
			hdr_exp <= ctrl.window_exponent;
			hdr_idx <= ctrl.frame_index;
			for (int i = 0; i < NUM_INPUTS*LAG_AUTO; i++)
				shadow[i] <= auto_counts[i];
			for (int j = 0; j < NUM_BASELINES*LAG_CROSS; j++)
				shadow[NUM_INPUTS*LAG_AUTO+j] <= cross_counts[j];
		end
	end

	always_ff @(posedge integration_clk) begin
		if (reset) begin
			sending  <= 1'b0;
			byte_idx <= '0;
		end else if (ctrl.capture) begin
			sending  <= 1'b1; // Header byte goes out next cycle.
			byte_idx <= '0;
		end else if (sending) begin
			if (byte_idx == byte_index_t'(FRAME_BYTES - 1)) begin
				sending  <= 1'b0;
				byte_idx <= '0;
			end else begin
				byte_idx <= byte_idx + byte_index_t'(1);
			end
		end
	end

	// Count bytes start after the two header bytes.
	assign count_sel = byte_idx - byte_index_t'(FRAME_BYTES - NUM_COUNTS);

	always_comb begin
		if (byte_idx == byte_index_t'(0))
			frame_byte = {FRAME_MARK, hdr_exp};
		else if (byte_idx == byte_index_t'(1))
			frame_byte = hdr_idx;
		else
			frame_byte = byte_t'(shadow[count_sel]);
	end

	assign byte_valid  = sending;
	assign frame_start = sending && (byte_idx == byte_index_t'(0));

endmodule

//--- correlator_top.sv
/*
 * Pulse correlator top level.
 * Delay line, auto and cross banks, window controller and byte serializer.
 */

`timescale 1ns/1ps

module correlator_top import correlator_pkg::*; (
	input  logic       integration_clk,
	input  logic       reset,
	input  pulse_vec_t line_in,
	input  logic       cmd_valid,
	input  byte_t      cmd_data,
	output byte_t      frame_byte,
	output logic       byte_valid,
	output logic       frame_start,
	output logic       integrating
);

	pulse_vec_t taps [DELAY_DEPTH];
	count_t     auto_counts [NUM_INPUTS*LAG_AUTO];
	count_t     cross_counts [NUM_BASELINES*LAG_CROSS];

	integration_ctrl_if ctrl_if ();

	pulse_delay_line u_delay_line (
		.integration_clk (integration_clk),
		.reset           (reset),
		.line_in         (line_in),
		.taps            (taps)
	);

	auto_correlator u_auto (
		.integration_clk (integration_clk),
		.reset           (reset),
		.taps            (taps),
		.ctrl            (ctrl_if.bank),
		.auto_counts     (auto_counts)
	);

	cross_correlator u_cross (
		.integration_clk (integration_clk),
		.reset           (reset),
		.taps            (taps),
		.ctrl            (ctrl_if.bank),
		.cross_counts    (cross_counts)
	);

	integration_control u_control (
		.integration_clk (integration_clk),
		.reset           (reset),
		.cmd_valid       (cmd_valid),
		.cmd_data        (cmd_data),
		.integrating     (integrating),
		.ctrl            (ctrl_if.control)
	);

	frame_serializer u_serializer (
		.integration_clk (integration_clk),
		.reset           (reset),
		.auto_counts     (auto_counts),
		.cross_counts    (cross_counts),
		.ctrl            (ctrl_if.serializer),
		.frame_byte      (frame_byte),
		.byte_valid      (byte_valid),
		.frame_start     (frame_start)
	);

endmodule

//--- tb_correlator.sv
/*
 * Testbench for the pulse correlator.
 * Drives pulse patterns and commands, models windows and counts, and checks
 * every output byte, strobe and the integrating flag cycle by cycle.
 */

`timescale 1ns/1ps

module tb_correlator import correlator_pkg::*; ();

	localparam int COUNT_MAX     = (1 << RESOLUTION) - 1;
	localparam int RESET_CYCLES  = 16;
	localparam int IDLE_CYCLES   = 20;
	localparam int RANDOM_CYCLES = 3 * 64;
	localparam int COPY_CYCLES   = 3 * 64;
	localparam int HIGH_CYCLES   = 64 + 2 * 512;
	localparam int SHORT_CYCLES  = 512 + 4 * 32;
	localparam int TAIL_CYCLES   = 32 + FRAME_BYTES + 100;
	localparam int CMD_CYCLES    = 7;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + 2 * IDLE_CYCLES + RANDOM_CYCLES + COPY_CYCLES
		+ HIGH_CYCLES + SHORT_CYCLES + TAIL_CYCLES + CMD_CYCLES + 200;

	typedef enum {PAT_RANDOM, PAT_COPY, PAT_HIGH} pattern_t;

	logic       integration_clk;
	logic       reset;
	pulse_vec_t line_in;
	logic       cmd_valid;
	byte_t      cmd_data;
	byte_t      frame_byte;
	logic       byte_valid;
	logic       frame_start;
	logic       integrating;

	pattern_t    mode;
	logic [31:0] rng;
	bit          checking;

	// Reference model state.
	bit         m_integ;
	bit         m_stop;
	int         m_exp;
	int         m_pending;
	int         m_count;
	int         m_idx;
	pulse_vec_t m_taps [DELAY_DEPTH];
	int         m_auto [NUM_INPUTS*LAG_AUTO];
	int         m_cross [NUM_BASELINES*LAG_CROSS];
	byte_t      exp_bytes [$]; // Bytes still owed by the DUT.

	int    cycle_count;
	int    frames_expected;
	int    sat_frames;
	int    lag_frames;
	int    min_frames;
	int    starts_seen;
	int    last_start;
	int    byte_pos;
	byte_t last_index;

	correlator_top i_dut (
		.integration_clk (integration_clk),
		.reset           (reset),
		.line_in         (line_in),
		.cmd_valid       (cmd_valid),
		.cmd_data        (cmd_data),
		.frame_byte      (frame_byte),
		.byte_valid      (byte_valid),
		.frame_start     (frame_start),
		.integrating     (integrating)
	);

	initial begin
		integration_clk = 1'b0;
		forever #10 integration_clk = ~integration_clk;
	end

	task automatic abort_run();
		$display(">>> FAIL");
		$fatal(1, "Simulation stopped on the first error.");
	endtask

	task automatic report_mismatch(string msg);
		$display("FAIL at %0t ns: %s", $time, msg);
		abort_run();
	endtask

	function automatic logic [31:0] xorshift32(logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Saturating counter rule; capture restarts with this cycle's hit.
	function automatic int next_count(int value, logic hit, logic accumulate, logic cap);
		if (cap)
			return int'(hit);
		if (accumulate && hit && value < COUNT_MAX)
			return value + 1;
		return value;
	endfunction

	task automatic push_frame();
		int full;
		full = 0;
		exp_bytes.push_back(byte_t'({FRAME_MARK, exponent_t'(m_exp)}));
		exp_bytes.push_back(byte_t'(m_idx));
		foreach (m_auto[i]) begin
			exp_bytes.push_back(byte_t'(m_auto[i]));
			if (m_auto[i] == COUNT_MAX)
				full++;
		end
		foreach (m_cross[i]) begin
			exp_bytes.push_back(byte_t'(m_cross[i]));
			if (m_cross[i] == COUNT_MAX)
				full++;
		end
		frames_expected++;
		if (full == NUM_COUNTS)
			sat_frames++;
		// Line 1 lagging line 0 shows up at lag -1 of pair (0,1).
		if (m_cross[0] > 0 && m_cross[0] == m_auto[LAG_AUTO] && m_cross[0] > m_cross[2])
			lag_frames++;
	endtask

	always @(posedge integration_clk) begin : reference_model
		logic hit;
		logic cap;
		int   p;
		int   opcode;
		int   arg;
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES) begin
			$display("Timeout: the test did not finish within %0d cycles.", TIMEOUT_CYCLES);
			abort_run();
		end
		checking = !reset;
		if (reset) begin
			m_integ   = 1'b0;
			m_stop    = 1'b0;
			m_exp     = MIN_EXPONENT;
			m_pending = MIN_EXPONENT;
			m_count   = 0;
			m_idx     = 0;
			foreach (m_taps[n])
				m_taps[n] = '0;
			foreach (m_auto[i])
				m_auto[i] = 0;
			foreach (m_cross[i])
				m_cross[i] = 0;
			exp_bytes.delete();
		end else begin
			cap = m_integ && (m_count == (1 << m_exp) - 1); // Last cycle of the window.
			if (cap)
				push_frame();
			for (int a = 0; a < NUM_INPUTS; a++) begin
				for (int y = 0; y < LAG_AUTO; y++) begin
					hit = m_taps[0][a] & m_taps[y][a];
					m_auto[a*LAG_AUTO+y] = next_count(m_auto[a*LAG_AUTO+y], hit, m_integ, cap);
				end
			end
			p = 0;
			for (int a = 0; a < NUM_INPUTS; a++) begin
				for (int b = a + 1; b < NUM_INPUTS; b++) begin
					hit = m_taps[1][a] & m_taps[0][b]; // Lag -1.
					m_cross[p*3] = next_count(m_cross[p*3], hit, m_integ, cap);
					hit = m_taps[0][a] & m_taps[0][b];
					m_cross[p*3+1] = next_count(m_cross[p*3+1], hit, m_integ, cap);
					hit = m_taps[0][a] & m_taps[1][b]; // Lag +1.
					m_cross[p*3+2] = next_count(m_cross[p*3+2], hit, m_integ, cap);
					p++;
				end
			end
			opcode = cmd_valid ? int'(cmd_data[7:4]) : 0;
			arg    = int'(cmd_data[3:0]);
			if (opcode == CMD_SET_WINDOW)
				m_pending = (arg < MIN_EXPONENT) ? MIN_EXPONENT :
					(arg > MAX_EXPONENT) ? MAX_EXPONENT : arg;
			if (!m_integ) begin
				if (opcode == CMD_START) begin
					m_integ = 1'b1;
					m_exp   = m_pending;
					m_count = 0;
					m_stop  = 1'b0;
				end
			end else begin
				if (opcode == CMD_STOP)
					m_stop = 1'b1;
				if (cap) begin
					m_count = 0;
					m_idx   = (m_idx + 1) % 256;
					m_exp   = m_pending;
					if (m_stop) begin
						m_integ = 1'b0;
						m_stop  = 1'b0;
					end
				end else begin
					m_count++;
				end
			end
			for (int n = DELAY_DEPTH - 1; n > 0; n--)
				m_taps[n] = m_taps[n-1];
			m_taps[0] = line_in;
		end
	end

	// Outputs are settled half a cycle after the rising edge.
	always @(negedge integration_clk) begin : output_checker
		byte_t expected;
		if (checking) begin
			assert (integrating === m_integ)
				else report_mismatch($sformatf("integrating is %b, expected %b", integrating,
					m_integ));
			assert (byte_valid === (exp_bytes.size() != 0))
				else report_mismatch($sformatf("byte_valid is %b with %0d bytes owed",
					byte_valid, exp_bytes.size()));
			assert (frame_start === (exp_bytes.size() == FRAME_BYTES))
				else report_mismatch($sformatf("frame_start is %b at the wrong byte",
					frame_start));
			if (byte_valid === 1'b1) begin
				if (frame_start === 1'b1) begin
					byte_pos = 0;
					assert (frame_byte[7:4] === FRAME_MARK)
						else report_mismatch($sformatf("header mark is %h", frame_byte[7:4]));
					if (starts_seen > 0) begin
						assert (cycle_count - last_start == (1 << frame_byte[3:0]))
							else report_mismatch($sformatf("frame spacing %0d for exponent %0d",
								cycle_count - last_start, frame_byte[3:0]));
					end
					if (frame_byte[3:0] == MIN_EXPONENT)
						min_frames++;
					last_start = cycle_count;
					starts_seen++;
				end
				if (byte_pos == 1) begin
					if (starts_seen > 1) begin
						assert (frame_byte === byte_t'(last_index + 1))
							else report_mismatch($sformatf("frame index %0d after %0d",
								frame_byte, last_index));
					end
					last_index = frame_byte;
				end
				expected = exp_bytes.pop_front();
				assert (frame_byte === expected)
					else report_mismatch($sformatf("frame byte %0d is %h, expected %h",
						byte_pos, frame_byte, expected));
				byte_pos++;
			end
		end
	end

	task automatic drive_lines();
		pulse_vec_t v;
		rng = xorshift32(rng);
		case (mode)
			PAT_COPY: begin
				v    = pulse_vec_t'(rng[18:16]);
				v[1] = line_in[0]; // Line 1 trails line 0 by one cycle.
			end
			PAT_HIGH: v = '1;
			default:  v = pulse_vec_t'(rng[18:16]);
		endcase
		line_in = v;
	endtask

	task automatic run_cycles(int n);
		repeat (n) begin
			@(negedge integration_clk);
			cmd_valid = 1'b0;
			cmd_data  = '0;
			drive_lines();
		end
	endtask

	task automatic send_cmd(logic [3:0] op, logic [3:0] arg);
		@(negedge integration_clk);
		cmd_valid = 1'b1;
		cmd_data  = {op, arg};
		drive_lines();
	endtask

	initial begin
		reset     = 1'b1;
		line_in   = '0;
		cmd_valid = 1'b0;
		cmd_data  = '0;
		rng       = 32'd84157;
		mode      = PAT_RANDOM;
		repeat (RESET_CYCLES) @(negedge integration_clk);
		reset = 1'b0;

		run_cycles(IDLE_CYCLES);        // Lines toggle, nothing counts.
		send_cmd(CMD_STOP, 4'd0);       // Ignored while idle.
		run_cycles(IDLE_CYCLES);
		send_cmd(CMD_SET_WINDOW, 4'd6);
		send_cmd(CMD_START, 4'd0);
		run_cycles(RANDOM_CYCLES / 2);
		send_cmd(CMD_START, 4'd0);      // Ignored in the middle of a window.
		run_cycles(RANDOM_CYCLES / 2);
		mode = PAT_COPY;
		run_cycles(COPY_CYCLES);
		mode = PAT_HIGH;
		send_cmd(CMD_SET_WINDOW, 4'd9);
		run_cycles(HIGH_CYCLES);
		mode = PAT_RANDOM;
		send_cmd(CMD_SET_WINDOW, 4'd2); // Clamps to the minimum.
		run_cycles(SHORT_CYCLES);
		send_cmd(CMD_STOP, 4'd0);
		run_cycles(TAIL_CYCLES);

		assert (starts_seen == frames_expected && exp_bytes.size() == 0)
			else report_mismatch($sformatf("%0d frames seen, %0d expected", starts_seen,
				frames_expected));
		assert (sat_frames > 0) else report_mismatch("no frame with every counter saturated");
		assert (lag_frames > 0) else report_mismatch("no frame showed the lag -1 coincidence");
		assert (min_frames > 0) else report_mismatch("no frame used the clamped exponent");
		assert (integrating === 1'b0)
			else report_mismatch("integration still running after stop");
		$display(">>> PASS");
		$finish;
	end

endmodule

//--- sources.f
correlator_pkg.sv
integration_ctrl_if.sv
pulse_delay_line.sv
auto_correlator.sv
cross_correlator.sv
integration_control.sv
frame_serializer.sv
correlator_top.sv
tb_correlator.sv
